//--- src/mcu_pkg.sv
/* Shared definitions for the small MCU fabric: bus widths, address map,
   region decode values and register offsets used by the RTL and testbench */
package mcu_pkg;

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Address map, upper nibble selects the region
  parameter addr_t RAM_BASE    = 32'h0000_0000;
  parameter addr_t GPIO_BASE   = 32'h2000_0000;
  parameter addr_t DMA_BASE    = 32'h3000_0000;
  parameter addr_t REGION_MASK = 32'hF000_0000;

  typedef enum logic [1:0] {
    REG_RAM,
    REG_GPIO,
    REG_DMA,
    REG_NONE
  } region_e;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WRITE,
    DMA_DONE
  } dma_state_e;

  // Word offsets inside the DMA and GPIO regions
  typedef enum logic [2:0] {
    DMA_SRC    = 3'd0,
    DMA_DST    = 3'd1,
    DMA_LEN    = 3'd2,
    DMA_CTRL   = 3'd3,
    DMA_STATUS = 3'd4
  } dma_reg_e;

  typedef enum logic [2:0] {
    GPIO_OUT         = 3'd0,
    GPIO_OE          = 3'd1,
    GPIO_IN          = 3'd2,
    GPIO_INTR_EN     = 3'd3,
    GPIO_INTR_STATUS = 3'd4
  } gpio_reg_e;

endpackage

//--- src/system_bus.sv
/* Shared APB bus with a two-master round-robin arbiter, region decoder
   and response routing; unmapped accesses are answered here with an error */
`timescale 1ns/1ps

module system_bus #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // Host master
  input  logic           m0_psel_i,
  input  logic           m0_penable_i,
  input  logic           m0_pwrite_i,
  input  mcu_pkg::addr_t m0_paddr_i,
  input  mcu_pkg::data_t m0_pwdata_i,
  output mcu_pkg::data_t m0_prdata_o,
  output logic           m0_pready_o,
  output logic           m0_pslverr_o,
  // DMA master
  input  logic           m1_psel_i,
  input  logic           m1_penable_i,
  input  logic           m1_pwrite_i,
  input  mcu_pkg::addr_t m1_paddr_i,
  input  mcu_pkg::data_t m1_pwdata_i,
  output mcu_pkg::data_t m1_prdata_o,
  output logic           m1_pready_o,
  output logic           m1_pslverr_o,
  // Targets
  output logic           s_penable_o,
  output logic           s_pwrite_o,
  output mcu_pkg::addr_t s_paddr_o,
  output mcu_pkg::data_t s_pwdata_o,
  output logic           ram_psel_o,
  output logic           gpio_psel_o,
  output logic           dma_psel_o,
  input  mcu_pkg::data_t ram_prdata_i,
  input  logic           ram_pready_i,
  input  mcu_pkg::data_t gpio_prdata_i,
  input  logic           gpio_pready_i,
  input  mcu_pkg::data_t dma_prdata_i,
  input  logic           dma_pready_i
);
  import mcu_pkg::*;

  localparam addr_t RAM_BYTES = addr_t'(NUM_BANKS * BANK_WORDS * 4);

  logic    busy_q;
  logic    owner_q;
  logic    last_q;
  logic    gnt_m0;
  logic    gnt_m1;
  logic    sel_active;
  region_e region;
  data_t   s_prdata;
  logic    s_pready;
  logic    s_pslverr;

  // Owner keeps the bus until pready, otherwise the last loser is preferred
  always_comb begin
    if (busy_q) begin
      gnt_m0 = ~owner_q;
      gnt_m1 = owner_q;
    end else begin
      gnt_m0 = m0_psel_i & (~m1_psel_i | last_q);
      gnt_m1 = m1_psel_i & (~m0_psel_i | ~last_q);
    end
  end

  assign sel_active  = gnt_m0 | gnt_m1;
  assign s_pwrite_o  = gnt_m1 ? m1_pwrite_i : m0_pwrite_i;
  assign s_paddr_o   = gnt_m1 ? m1_paddr_i : m0_paddr_i;
  assign s_pwdata_o  = gnt_m1 ? m1_pwdata_i : m0_pwdata_i;
  // Bus runs its own setup cycle after each new grant
  assign s_penable_o = busy_q & (gnt_m1 ? m1_penable_i : m0_penable_i);

  always_comb begin
    if ((s_paddr_o & REGION_MASK) == RAM_BASE && (s_paddr_o & ~REGION_MASK) < RAM_BYTES) begin
      region = REG_RAM;
    end else if ((s_paddr_o & REGION_MASK) == GPIO_BASE) begin
      region = REG_GPIO;
    end else if ((s_paddr_o & REGION_MASK) == DMA_BASE) begin
      region = REG_DMA;
    end else begin
      region = REG_NONE;
    end
  end

  assign ram_psel_o  = sel_active && region == REG_RAM;
  assign gpio_psel_o = sel_active && region == REG_GPIO;
  assign dma_psel_o  = sel_active && region == REG_DMA;

  always_comb begin
    s_prdata  = '0;
    s_pready  = 1'b0;
    s_pslverr = 1'b0;
    unique case (region)
      REG_RAM: begin
        s_prdata = ram_prdata_i;
        s_pready = ram_pready_i;
      end
      REG_GPIO: begin
        s_prdata = gpio_prdata_i;
        s_pready = gpio_pready_i;
      end
      REG_DMA: begin
        s_prdata = dma_prdata_i;
        s_pready = dma_pready_i;
      end
      default: begin
        s_pready  = s_penable_o;
        s_pslverr = s_penable_o;
      end
    endcase
  end

  assign m0_prdata_o  = gnt_m0 ? s_prdata : '0;
  assign m0_pready_o  = gnt_m0 & s_pready;
  assign m0_pslverr_o = gnt_m0 & s_pslverr;
  assign m1_prdata_o  = gnt_m1 ? s_prdata : '0;
  assign m1_pready_o  = gnt_m1 & s_pready;
  assign m1_pslverr_o = gnt_m1 & s_pslverr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;
    end else if (!busy_q && sel_active) begin
      busy_q  <= 1'b1;
      owner_q <= gnt_m1;
      last_q  <= gnt_m1;
    end else if (busy_q && s_pready) begin
      busy_q <= 1'b0;
    end
  end

  // One requesting owner holds the grant from setup to pready
  a_grant_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sel_active && !(busy_q && s_pready)
      |=> $onehot({gnt_m0 & m0_psel_i, gnt_m1 & m1_psel_i}) && $stable(gnt_m1));

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sel_active && !(busy_q && s_pready) |=> $stable(s_paddr_o));

endmodule

//--- src/sram_banks.sv
/* Word-interleaved SRAM behind an APB slave port; consecutive words map
   to consecutive banks, zero wait states */
`timescale 1ns/1ps

module sram_banks #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  mcu_pkg::addr_t paddr_i,
  input  mcu_pkg::data_t pwdata_i,
  output mcu_pkg::data_t prdata_o,
  output logic           pready_o
);
  import mcu_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int ROW_BITS  = $clog2(BANK_WORDS);

  data_t                mem [NUM_BANKS][BANK_WORDS];
  logic [BANK_BITS-1:0] bank_idx;
  logic [ROW_BITS-1:0]  row_idx;
  logic                 access;

  // Low word-address bits pick the bank
  assign bank_idx = paddr_i[2 +: BANK_BITS];
  assign row_idx  = paddr_i[2 + BANK_BITS +: ROW_BITS];
  assign access   = psel_i & penable_i;
  assign pready_o = access;
  assign prdata_o = access ? mem[bank_idx][row_idx] : '0;

  always_ff @(posedge clk_i) begin
    if (access && pwrite_i) begin
      mem[bank_idx][row_idx] <= pwdata_i;
    end
  end

  // Decoder upstream must keep selects inside the RAM
  a_bank_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    psel_i |-> int'(bank_idx) < NUM_BANKS
      && (paddr_i & ~REGION_MASK) < addr_t'(NUM_BANKS * BANK_WORDS * 4));

endmodule

//--- src/dma_engine.sv
/* Single-channel DMA: APB register slave plus an APB master that copies
   LEN words from SRC to DST, one read and one write per word */
`timescale 1ns/1ps

module dma_engine (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // Register slave
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  mcu_pkg::addr_t paddr_i,
  input  mcu_pkg::data_t pwdata_i,
  output mcu_pkg::data_t prdata_o,
  output logic           pready_o,
  // Copy master
  output logic           m_psel_o,
  output logic           m_penable_o,
  output logic           m_pwrite_o,
  output mcu_pkg::addr_t m_paddr_o,
  output mcu_pkg::data_t m_pwdata_o,
  input  mcu_pkg::data_t m_prdata_i,
  input  logic           m_pready_i,
  input  logic           m_pslverr_i,
  output logic           irq_o
);
  import mcu_pkg::*;

  dma_state_e state_q;
  dma_reg_e   reg_sel;
  addr_t      src_q;
  addr_t      dst_q;
  data_t      len_q;
  data_t      rd_buf_q;
  logic       pen_q;
  logic       done_q;
  logic       err_q;
  logic       wr_en;
  logic       busy;
  logic       xfer_done;
  logic       last_word;

  assign reg_sel   = dma_reg_e'(paddr_i[4:2]);
  assign wr_en     = psel_i & penable_i & pwrite_i;
  assign pready_o  = psel_i & penable_i;
  assign busy      = state_q != DMA_IDLE;
  assign xfer_done = pen_q & m_pready_i;
  assign last_word = state_q == DMA_WRITE && len_q == data_t'(1);

  always_comb begin
    unique case (reg_sel)
      DMA_SRC:    prdata_o = src_q;
      DMA_DST:    prdata_o = dst_q;
      DMA_LEN:    prdata_o = len_q;
      DMA_STATUS: prdata_o = data_t'({busy, err_q, done_q});
      default:    prdata_o = '0;
    endcase
  end

  assign m_psel_o    = state_q == DMA_READ || state_q == DMA_WRITE;
  assign m_penable_o = pen_q;
  assign m_pwrite_o  = state_q == DMA_WRITE;
  assign m_paddr_o   = (state_q == DMA_WRITE) ? dst_q : src_q;
  assign m_pwdata_o  = rd_buf_q;
  assign irq_o       = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= DMA_IDLE;
      pen_q   <= 1'b0;
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      // Write 1 to done clears both flags
      if (wr_en && reg_sel == DMA_STATUS && pwdata_i[0]) begin
        done_q <= 1'b0;
        err_q  <= 1'b0;
      end
      unique case (state_q)
        DMA_IDLE: begin
          if (wr_en) begin
            case (reg_sel)
              DMA_SRC: src_q <= pwdata_i;
              DMA_DST: dst_q <= pwdata_i;
              DMA_LEN: len_q <= pwdata_i;
              DMA_CTRL: begin
                if (pwdata_i[0] && len_q != '0) begin
                  state_q <= DMA_READ;
                end
              end
              default: ;
            endcase
          end
        end
        DMA_READ, DMA_WRITE: begin
          if (!pen_q) begin
            pen_q <= 1'b1;
          end else if (m_pready_i) begin
            pen_q <= 1'b0;
            if (m_pslverr_i || last_word) begin
              state_q <= DMA_DONE;
              done_q  <= 1'b1;
              err_q   <= m_pslverr_i;
            end else if (state_q == DMA_READ) begin
              state_q <= DMA_WRITE;
            end else begin
              state_q <= DMA_READ;
            end
            if (state_q == DMA_WRITE && !m_pslverr_i) begin
              src_q <= src_q + addr_t'(4);
              dst_q <= dst_q + addr_t'(4);
              len_q <= len_q - data_t'(1);
            end
          end
        end
        default: state_q <= DMA_IDLE;
      endcase
    end
  end

  // Word held between the read and the write
  always_ff @(posedge clk_i) begin
    if (state_q == DMA_READ && xfer_done && !m_pslverr_i) begin
      rd_buf_q <= m_prdata_i;
    end
  end

  a_psel_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_psel_o && !xfer_done |=> m_psel_o);

  a_capture_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$stable(rd_buf_q) |-> $past(state_q == DMA_READ && m_pready_i));

endmodule

//--- src/gpio_ctrl.sv
/* GPIO block: output and output-enable registers, synchronized inputs and
   rising-edge interrupt status with write-1-to-clear */
`timescale 1ns/1ps

module gpio_ctrl #(
  parameter int NUM_GPIO = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  mcu_pkg::addr_t      paddr_i,
  input  mcu_pkg::data_t      pwdata_i,
  output mcu_pkg::data_t      prdata_o,
  output logic                pready_o,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                irq_o
);
  import mcu_pkg::*;

  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] ie_q;
  logic [NUM_GPIO-1:0] status_q;
  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] rdata;
  gpio_reg_e           reg_sel;
  logic                wr_en;

  assign reg_sel  = gpio_reg_e'(paddr_i[4:2]);
  assign wr_en    = psel_i & penable_i & pwrite_i;
  assign pready_o = psel_i & penable_i;
  assign rise     = sync2_q & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      out_q    <= '0;
      oe_q     <= '0;
      ie_q     <= '0;
      status_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && reg_sel == GPIO_OUT) out_q <= pwdata_i[NUM_GPIO-1:0];
      if (wr_en && reg_sel == GPIO_OE) oe_q <= pwdata_i[NUM_GPIO-1:0];
      if (wr_en && reg_sel == GPIO_INTR_EN) ie_q <= pwdata_i[NUM_GPIO-1:0];
      // New edges win over a clear in the same cycle
      if (wr_en && reg_sel == GPIO_INTR_STATUS) begin
        status_q <= (status_q & ~pwdata_i[NUM_GPIO-1:0]) | rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

  always_comb begin
    unique case (reg_sel)
      GPIO_OUT:         rdata = out_q;
      GPIO_OE:          rdata = oe_q;
      GPIO_IN:          rdata = sync2_q;
      GPIO_INTR_EN:     rdata = ie_q;
      GPIO_INTR_STATUS: rdata = status_q;
      default:          rdata = '0;
    endcase
  end

  assign prdata_o  = data_t'(rdata);
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |(status_q & ie_q);

endmodule

//--- src/mini_mcu.sv
/* Top level of the reduced MCU: host port and DMA share one APB bus
   to the banked SRAM, the GPIO block and the DMA registers */
`timescale 1ns/1ps

module mini_mcu #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64,
  parameter int NUM_GPIO   = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                host_psel_i,
  input  logic                host_penable_i,
  input  logic                host_pwrite_i,
  input  mcu_pkg::addr_t      host_paddr_i,
  input  mcu_pkg::data_t      host_pwdata_i,
  output mcu_pkg::data_t      host_prdata_o,
  output logic                host_pready_o,
  output logic                host_pslverr_o,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                dma_irq_o,
  output logic                gpio_irq_o
);
  import mcu_pkg::*;

  // DMA master side
  logic  dma_m_psel, dma_m_penable, dma_m_pwrite;
  addr_t dma_m_paddr;
  data_t dma_m_pwdata, dma_m_prdata;
  logic  dma_m_pready, dma_m_pslverr;

  // Shared target bus
  logic  s_penable, s_pwrite;
  addr_t s_paddr;
  data_t s_pwdata;
  logic  ram_psel, gpio_psel, dma_psel;
  data_t ram_prdata, gpio_prdata, dma_prdata;
  logic  ram_pready, gpio_pready, dma_pready;

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i,
    .arst_n_i,
    .m0_psel_i    (host_psel_i),
    .m0_penable_i (host_penable_i),
    .m0_pwrite_i  (host_pwrite_i),
    .m0_paddr_i   (host_paddr_i),
    .m0_pwdata_i  (host_pwdata_i),
    .m0_prdata_o  (host_prdata_o),
    .m0_pready_o  (host_pready_o),
    .m0_pslverr_o (host_pslverr_o),
    .m1_psel_i    (dma_m_psel),
    .m1_penable_i (dma_m_penable),
    .m1_pwrite_i  (dma_m_pwrite),
    .m1_paddr_i   (dma_m_paddr),
    .m1_pwdata_i  (dma_m_pwdata),
    .m1_prdata_o  (dma_m_prdata),
    .m1_pready_o  (dma_m_pready),
    .m1_pslverr_o (dma_m_pslverr),
    .s_penable_o  (s_penable),
    .s_pwrite_o   (s_pwrite),
    .s_paddr_o    (s_paddr),
    .s_pwdata_o   (s_pwdata),
    .ram_psel_o   (ram_psel),
    .gpio_psel_o  (gpio_psel),
    .dma_psel_o   (dma_psel),
    .ram_prdata_i (ram_prdata),
    .ram_pready_i (ram_pready),
    .gpio_prdata_i(gpio_prdata),
    .gpio_pready_i(gpio_pready),
    .dma_prdata_i (dma_prdata),
    .dma_pready_i (dma_pready)
  );

  sram_banks #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) sram_banks_i (
    .clk_i,
    .arst_n_i,
    .psel_i   (ram_psel),
    .penable_i(s_penable),
    .pwrite_i (s_pwrite),
    .paddr_i  (s_paddr),
    .pwdata_i (s_pwdata),
    .prdata_o (ram_prdata),
    .pready_o (ram_pready)
  );

  gpio_ctrl #(
    .NUM_GPIO(NUM_GPIO)
  ) gpio_ctrl_i (
    .clk_i,
    .arst_n_i,
    .psel_i   (gpio_psel),
    .penable_i(s_penable),
    .pwrite_i (s_pwrite),
    .paddr_i  (s_paddr),
    .pwdata_i (s_pwdata),
    .prdata_o (gpio_prdata),
    .pready_o (gpio_pready),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_o    (gpio_irq_o)
  );

  dma_engine dma_engine_i (
    .clk_i,
    .arst_n_i,
    .psel_i     (dma_psel),
    .penable_i  (s_penable),
    .pwrite_i   (s_pwrite),
    .paddr_i    (s_paddr),
    .pwdata_i   (s_pwdata),
    .prdata_o   (dma_prdata),
    .pready_o   (dma_pready),
    .m_psel_o   (dma_m_psel),
    .m_penable_o(dma_m_penable),
    .m_pwrite_o (dma_m_pwrite),
    .m_paddr_o  (dma_m_paddr),
    .m_pwdata_o (dma_m_pwdata),
    .m_prdata_i (dma_m_prdata),
    .m_pready_i (dma_m_pready),
    .m_pslverr_i(dma_m_pslverr),
    .irq_o      (dma_irq_o)
  );

endmodule

//--- tb/tb_mini_mcu.sv
/* Testbench for the reduced MCU: applies a table of host bus accesses, pin changes
   and interrupt waits to the top level and checks the results against a RAM model */
`timescale 1ns/1ps

module tb_mini_mcu;
  import mcu_pkg::*;

  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 64;
  localparam int NUM_GPIO   = 8;
  localparam int RAM_BYTES  = NUM_BANKS * BANK_WORDS * 4;
  localparam int FILL_WORDS = 16;
  localparam int COPY_WORDS = 8;
  localparam int ERR_WORDS  = 4;
  localparam addr_t SRC_BLK  = 32'h0000_0200;
  localparam addr_t DST_BLK  = 32'h0000_0280;
  localparam addr_t DST2_BLK = 32'h0000_0300;
  localparam data_t IRQ_DMA  = 32'd0;
  localparam data_t IRQ_GPIO = 32'd1;

  typedef enum int {OP_WRITE, OP_READ, OP_WAIT_IRQ, OP_SET_PINS} op_e;

  logic                clk_i;
  logic                arst_n_i;
  logic                host_psel_i;
  logic                host_penable_i;
  logic                host_pwrite_i;
  addr_t               host_paddr_i;
  data_t               host_pwdata_i;
  data_t               host_prdata_o;
  logic                host_pready_o;
  logic                host_pslverr_o;
  logic [NUM_GPIO-1:0] gpio_i;
  logic [NUM_GPIO-1:0] gpio_o;
  logic [NUM_GPIO-1:0] gpio_oe_o;
  logic                dma_irq_o;
  logic                gpio_irq_o;

  // Stimulus table, one entry per index
  string name_q[$];
  op_e   op_q[$];
  addr_t addr_q[$];
  data_t data_q[$];
  data_t exp_q[$];

  data_t ram_model[addr_t];
  data_t rng_state = 32'd97;
  int    cycle_cnt = 0;
  int    cycle_limit = 0;

  mini_mcu #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS),
    .NUM_GPIO  (NUM_GPIO)
  ) DUT (
    .clk_i, .arst_n_i, .host_psel_i, .host_penable_i, .host_pwrite_i, .host_paddr_i,
    .host_pwdata_i, .host_prdata_o, .host_pready_o, .host_pslverr_o,
    .gpio_i, .gpio_o, .gpio_oe_o, .dma_irq_o, .gpio_irq_o
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic data_t next_random();
    data_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Address map: upper nibble picks the region, RAM ends at its size
  function automatic bit in_ram(input addr_t addr);
    return (addr & REGION_MASK) == RAM_BASE && (addr & ~REGION_MASK) < addr_t'(RAM_BYTES);
  endfunction

  function automatic bit is_mapped(input addr_t addr);
    return in_ram(addr) || (addr & REGION_MASK) == GPIO_BASE || (addr & REGION_MASK) == DMA_BASE;
  endfunction

  function automatic addr_t gpio_reg(input gpio_reg_e r);
    return GPIO_BASE | (addr_t'(r) << 2);
  endfunction

  function automatic addr_t dma_reg(input dma_reg_e r);
    return DMA_BASE | (addr_t'(r) << 2);
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (exp === act) else begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic add_entry(input string name, input op_e op, input addr_t addr,
                           input data_t data, input data_t exp);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  task automatic add_write(input string name, input addr_t addr, input data_t data);
    if (in_ram(addr)) begin
      ram_model[addr] = data;
    end
    add_entry(name, OP_WRITE, addr, data, '0);
  endtask

  task automatic add_ram_read(input string name, input addr_t addr);
    data_t exp;
    exp = '0;
    if (in_ram(addr) && ram_model.exists(addr)) begin
      exp = ram_model[addr];
    end
    add_entry(name, OP_READ, addr, '0, exp);
  endtask

  task automatic build_table();
    data_t d;
    // Stride of 17 words touches every bank
    for (int i = 0; i < FILL_WORDS; i++) begin
      add_write($sformatf("ram fill %0d", i), addr_t'(i * 68), next_random());
    end
    for (int i = 0; i < 4; i++) begin
      add_write($sformatf("ram overwrite %0d", i), addr_t'(i * 68), next_random());
    end
    for (int i = 0; i < FILL_WORDS; i++) begin
      add_ram_read($sformatf("ram readback %0d", i), addr_t'(i * 68));
    end
    add_ram_read("unmapped read 4", 32'h4000_0000);
    add_write("unmapped write 4", 32'h4000_0000, next_random());
    add_ram_read("ram beyond size read", addr_t'(RAM_BYTES));
    add_write("ram beyond size write", addr_t'(RAM_BYTES), next_random());
    add_ram_read("unmapped read 1", 32'h1000_0000);
    add_ram_read("unmapped read f", 32'hF000_0010);
    add_ram_read("ram word 0 intact", 32'h0000_0000);
    d = next_random();
    add_write("gpio out", gpio_reg(GPIO_OUT), d);
    add_entry("gpio out read", OP_READ, gpio_reg(GPIO_OUT), '0, d & 32'hFF);
    add_write("gpio oe", gpio_reg(GPIO_OE), next_random());
    add_write("gpio out again", gpio_reg(GPIO_OUT), next_random());
    add_entry("pins a5", OP_SET_PINS, '0, 32'hA5, '0);
    add_entry("gpio in a5", OP_READ, gpio_reg(GPIO_IN), '0, 32'hA5);
    add_entry("pins 5a", OP_SET_PINS, '0, 32'h5A, '0);
    add_entry("gpio in 5a", OP_READ, gpio_reg(GPIO_IN), '0, 32'h5A);
    add_entry("pins low", OP_SET_PINS, '0, 32'h00, '0);
    add_write("gpio status flush", gpio_reg(GPIO_INTR_STATUS), 32'hFF);
    add_entry("gpio status empty", OP_READ, gpio_reg(GPIO_INTR_STATUS), '0, 32'h0);
    // Pin 0 enabled, pin 1 left disabled
    add_write("gpio irq enable", gpio_reg(GPIO_INTR_EN), 32'h01);
    add_entry("pin 0 rise", OP_SET_PINS, '0, 32'h01, '0);
    add_entry("gpio irq high", OP_WAIT_IRQ, '0, IRQ_GPIO, 32'h1);
    add_entry("gpio status pin 0", OP_READ, gpio_reg(GPIO_INTR_STATUS), '0, 32'h01);
    add_write("gpio clear pin 0", gpio_reg(GPIO_INTR_STATUS), 32'h01);
    add_entry("gpio irq low", OP_WAIT_IRQ, '0, IRQ_GPIO, 32'h0);
    add_entry("gpio status cleared", OP_READ, gpio_reg(GPIO_INTR_STATUS), '0, 32'h0);
    add_entry("pin 1 rise", OP_SET_PINS, '0, 32'h03, '0);
    add_entry("gpio status pin 1", OP_READ, gpio_reg(GPIO_INTR_STATUS), '0, 32'h02);
    add_entry("gpio irq stays low", OP_WAIT_IRQ, '0, IRQ_GPIO, 32'h0);
    add_write("gpio clear pin 1", gpio_reg(GPIO_INTR_STATUS), 32'h02);
    for (int i = 0; i < COPY_WORDS; i++) begin
      add_write($sformatf("dma src fill %0d", i), SRC_BLK + addr_t'(4 * i), next_random());
    end
    add_write("dma set src", dma_reg(DMA_SRC), SRC_BLK);
    add_write("dma set dst", dma_reg(DMA_DST), DST_BLK);
    add_write("dma set len", dma_reg(DMA_LEN), data_t'(COPY_WORDS));
    add_write("dma start", dma_reg(DMA_CTRL), 32'h1);
    for (int i = 0; i < FILL_WORDS; i++) begin
      add_ram_read($sformatf("host read under dma %0d", i), addr_t'(i * 68));
    end
    add_entry("dma done irq", OP_WAIT_IRQ, '0, IRQ_DMA, 32'h1);
    add_entry("dma status done", OP_READ, dma_reg(DMA_STATUS), '0, 32'h1);
    for (int i = 0; i < COPY_WORDS; i++) begin
      ram_model[DST_BLK + addr_t'(4 * i)] = ram_model[SRC_BLK + addr_t'(4 * i)];
      add_ram_read($sformatf("dma dst %0d", i), DST_BLK + addr_t'(4 * i));
    end
    add_write("dma clear", dma_reg(DMA_STATUS), 32'h1);
    add_entry("dma irq cleared", OP_WAIT_IRQ, '0, IRQ_DMA, 32'h0);
    add_entry("dma status idle", OP_READ, dma_reg(DMA_STATUS), '0, 32'h0);
    // Copy from an unmapped source must leave the destination alone
    for (int i = 0; i < ERR_WORDS; i++) begin
      add_write($sformatf("dma err dst fill %0d", i), DST2_BLK + addr_t'(4 * i), next_random());
    end
    add_write("dma err src", dma_reg(DMA_SRC), 32'h5000_0000);
    add_write("dma err dst", dma_reg(DMA_DST), DST2_BLK);
    add_write("dma err len", dma_reg(DMA_LEN), data_t'(ERR_WORDS));
    add_write("dma err start", dma_reg(DMA_CTRL), 32'h1);
    add_entry("dma err irq", OP_WAIT_IRQ, '0, IRQ_DMA, 32'h1);
    add_entry("dma status error", OP_READ, dma_reg(DMA_STATUS), '0, 32'h3);
    for (int i = 0; i < ERR_WORDS; i++) begin
      add_ram_read($sformatf("dma err dst %0d", i), DST2_BLK + addr_t'(4 * i));
    end
    add_write("dma err clear", dma_reg(DMA_STATUS), 32'h1);
  endtask

  task automatic host_transfer(input logic wr, input addr_t addr, input data_t wdata,
                               output data_t rdata, output logic slverr);
    @(posedge clk_i);
    #1;
    host_psel_i    = 1'b1;
    host_penable_i = 1'b0;
    host_pwrite_i  = wr;
    host_paddr_i   = addr;
    host_pwdata_i  = wdata;
    @(posedge clk_i);
    #1;
    host_penable_i = 1'b1;
    @(negedge clk_i);
    while (!host_pready_o) begin
      @(negedge clk_i);
    end
    rdata  = host_prdata_o;
    slverr = host_pslverr_o;
    @(posedge clk_i);
    #1;
    host_psel_i    = 1'b0;
    host_penable_i = 1'b0;
  endtask

  task automatic drive_pins(input logic [NUM_GPIO-1:0] pins);
    @(posedge clk_i);
    #1;
    gpio_i = pins;
    repeat (3) @(posedge clk_i);
  endtask

  task automatic wait_for_irq(input data_t which, input logic level);
    @(negedge clk_i);
    while (((which == IRQ_DMA) ? dma_irq_o : gpio_irq_o) !== level) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    data_t               rdata;
    logic                slverr;
    logic [NUM_GPIO-1:0] exp_out;
    logic [NUM_GPIO-1:0] exp_oe;
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    host_psel_i    = 1'b0;
    host_penable_i = 1'b0;
    host_pwrite_i  = 1'b0;
    host_paddr_i   = '0;
    host_pwdata_i  = '0;
    gpio_i         = '0;
    exp_out        = '0;
    exp_oe         = '0;
    build_table();
    cycle_limit = 30 * name_q.size() + 40 * (COPY_WORDS + ERR_WORDS);
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("reset state", '0, data_t'({host_pready_o, host_pslverr_o, dma_irq_o,
                                            gpio_irq_o, gpio_o, gpio_oe_o}));
    for (int i = 0; i < name_q.size(); i++) begin
      case (op_q[i])
        OP_WRITE: begin
          host_transfer(1'b1, addr_q[i], data_q[i], rdata, slverr);
          check_value({name_q[i], " pslverr"}, data_t'(!is_mapped(addr_q[i])), data_t'(slverr));
          if (addr_q[i] == gpio_reg(GPIO_OUT)) begin
            exp_out = data_q[i][NUM_GPIO-1:0];
          end
          if (addr_q[i] == gpio_reg(GPIO_OE)) begin
            exp_oe = data_q[i][NUM_GPIO-1:0];
          end
        end
        OP_READ: begin
          host_transfer(1'b0, addr_q[i], '0, rdata, slverr);
          check_value(name_q[i], exp_q[i], rdata);
          check_value({name_q[i], " pslverr"}, data_t'(!is_mapped(addr_q[i])), data_t'(slverr));
        end
        OP_WAIT_IRQ: wait_for_irq(data_q[i], exp_q[i][0]);
        default: drive_pins(data_q[i][NUM_GPIO-1:0]);
      endcase
      // Pins follow the last GPIO_OUT and GPIO_OE writes
      check_value({name_q[i], " pins"}, data_t'({exp_oe, exp_out}), data_t'({gpio_oe_o, gpio_o}));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- sources.f
src/mcu_pkg.sv
src/system_bus.sv
src/sram_banks.sv
src/dma_engine.sv
src/gpio_ctrl.sv
src/mini_mcu.sv
tb/tb_mini_mcu.sv

//--- Makefile
# Verilator flow for the reduced MCU testbench
# Example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
